// File: files.f
src/video_pkg.sv
src/pxl_cen_gen.sv
src/cpu_port.sv
src/prio_prom.sv
src/palette_ram.sv
src/blank_delay.sv
src/colmix.sv
src/video_mixer_top.sv
verification/tb_video_mixer.sv

// File: run_sim.sh
#!/bin/sh
# builds the video mixer testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_video_mixer -f files.f \
    -o tb_video_mixer \
    && ./obj_dir/tb_video_mixer | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "\*\* FAIL \*\*" sim.log \
    && { echo "simulation reported failure"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log \
    || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: verification/tb_video_mixer.sv
// video mixer testbench with cpu load, random pixels, reference model, watchdog and checks
`timescale 1ns/100ps
`default_nettype none

module tb_video_mixer import video_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int N_PAL        = 1 << PAL_AW;
    localparam int N_PROM       = 1 << PROM_AW;
    localparam int N_WRITES     = 2 * N_PAL + N_PROM;
    localparam int N_PIX        = 1600;
    localparam int HOLD_CLK     = 6;  // req kept high past a pixel enable on the first writes
    localparam int WATCHDOG_CLK = N_WRITES * 16 + (N_PIX + PIPE_DLY + 8) * CEN_DIV + 2000;

    logic        clk = 1'b0;
    logic        reset;
    char_code_t  char_pxl;
    scr_code_t   scr_pxl;
    obj_code_t   obj_pxl;
    logic        char_on;
    logic        scr_on;
    logic        obj_on;
    logic        lhbl;
    logic        lvbl;
    rgb4_t       red;
    rgb4_t       green;
    rgb4_t       blue;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        cpu_req;
    cpu_target_e cpu_sel;
    pal_addr_t   cpu_addr;
    cpu_data_t   cpu_data;
    logic        cpu_ack;

    cpu_data_t   rg_model   [0:N_PAL-1];   // what the cpu wrote with red in the high nibble
    rgb4_t       b_model    [0:N_PAL-1];
    sel_code_t   prom_model [0:N_PROM-1];
    logic [31:0] rng;
    int          div_cnt;      // own copy of the pixel divider
    int          strobe_cnt;   // write strobes seen inside the dut
    int          err_count;
    int          check_count;
    logic [13:0] exp_q [$];    // {lhbl, lvbl, r, g, b} per pixel in flight

    video_mixer_top u_dut (
        .clk      (clk),      .reset    (reset),
        .char_pxl (char_pxl), .scr_pxl  (scr_pxl),  .obj_pxl (obj_pxl),
        .char_on  (char_on),  .scr_on   (scr_on),   .obj_on  (obj_on),
        .lhbl     (lhbl),     .lvbl     (lvbl),
        .red      (red),      .green    (green),    .blue    (blue),
        .lhbl_dly (lhbl_dly), .lvbl_dly (lvbl_dly),
        .cpu_req  (cpu_req),  .cpu_sel  (cpu_sel),  .cpu_addr (cpu_addr),
        .cpu_data (cpu_data), .cpu_ack  (cpu_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // divide by 4 from reset release so the last count marks a pixel enable edge
    always @(posedge clk) begin
        if (reset) div_cnt <= 0;
        else       div_cnt <= (div_cnt + 1) % CEN_DIV;
    end

    always @(posedge clk) begin
        if (reset) strobe_cnt <= 0;
        else if (u_dut.we_rg || u_dut.we_b || u_dut.we_prio) strobe_cnt <= strobe_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference colour from transparency, priority group, prom word and zero-extended code
    function automatic logic [11:0] expected_rgb(input char_code_t c, input scr_code_t s,
                                                 input obj_code_t o, input logic [2:0] on);
        logic       c_op;
        logic       o_op;
        logic [1:0] grp;
        sel_code_t  w;
        logic [7:0] code;
        pal_addr_t  idx;
        c_op = on[2] && (c[1:0] != 2'b11);  // char colour 3 is clear
        o_op = on[0] && (o[3:0] != 4'hf);   // obj colour 15 is clear
        grp  = (s[7] || !on[1]) ? 2'd0 : s[6:5] + 2'd1;
        w    = prom_model[{c_op, o_op, grp, s[3:0]}];
        case (w[1:0])
            2'b11:   code = {1'b0, c};
            2'b10:   code = s;
            2'b01:   code = {1'b0, o};
            default: code = 8'h00;  // bank colour 0 when nothing shows
        endcase
        idx = {w[3:2], code};
        return {rg_model[idx], b_model[idx]};
    endfunction

    task automatic compare_value(input string name, input int got, input int want);
        check_count++;
        assert (got == want) else begin
            err_count++;
            $display("[ERROR] %0d ns %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        check_count++;
        assert (cond) else begin
            err_count++;
            $display("[ERROR] %0d ns %s", $time, msg);
        end
    endtask

    // one four-phase handshake with req optionally held past ack
    task automatic cpu_write(input cpu_target_e sel, input pal_addr_t addr,
                             input cpu_data_t data, input int hold);
        int n;
        int first;
        first = strobe_cnt;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_sel  <= sel;
        cpu_addr <= addr;
        cpu_data <= data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ack && n < 16);
        expect_true(cpu_ack, "cpu_ack never rose after cpu_req");
        expect_true(n <= 5, "cpu_ack came more than 4 clk after cpu_req");  // n counts one extra
        repeat (hold) begin
            @(negedge clk);
            expect_true(cpu_ack, "cpu_ack fell while cpu_req was still high");
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (cpu_ack && n < 8);
        expect_true(!cpu_ack && n <= 2, "cpu_ack did not drop after cpu_req fell");
        compare_value("write strobes per handshake", strobe_cnt - first, 1);
    endtask

    task automatic next_pixel_edge();
        @(posedge clk);
        while (div_cnt != CEN_DIV - 1) @(posedge clk);
    endtask

    task automatic check_pixel(input logic [13:0] e);
        logic act;
        act = e[13] && e[12];
        compare_value("lhbl_dly", int'(lhbl_dly), int'(e[13]));
        compare_value("lvbl_dly", int'(lvbl_dly), int'(e[12]));
        compare_value("red",   int'(red),   act ? int'(e[11:8]) : 0);
        compare_value("green", int'(green), act ? int'(e[7:4])  : 0);
        compare_value("blue",  int'(blue),  act ? int'(e[3:0])  : 0);
        expect_true((lhbl_dly && lvbl_dly) || ({red, green, blue} == 12'h000),
                    "colour is not black while a delayed blanking flag is low");
    endtask

    initial begin
        int         i;
        int         p;
        logic [2:0] ons;  // {char, scr, obj}
        logic       hb;
        logic       vb;
        char_code_t cv;
        scr_code_t  sv;
        obj_code_t  ov;
        rng         = 32'd57724;
        err_count   = 0;
        check_count = 0;
        reset       = 1'b1;
        char_pxl    = '0;
        scr_pxl     = '0;
        obj_pxl     = '0;
        char_on     = 1'b0;
        scr_on      = 1'b0;
        obj_on      = 1'b0;
        lhbl        = 1'b0;
        lvbl        = 1'b0;
        cpu_req     = 1'b0;
        cpu_sel     = TGT_RG;
        cpu_addr    = '0;
        cpu_data    = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // idle outputs before any request
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            compare_value("cpu_ack", int'(cpu_ack), 0);
            compare_value("rgb", int'({red, green, blue}), 0);
            compare_value("lhbl_dly", int'(lhbl_dly), 0);
            compare_value("lvbl_dly", int'(lvbl_dly), 0);
        end

        for (i = 0; i < N_PAL; i++) begin
            rng = xorshift32(rng);
            rg_model[i] = rng[7:0];
            cpu_write(TGT_RG, pal_addr_t'(i), rng[7:0], (i < 8) ? HOLD_CLK : 0);
        end
        for (i = 0; i < N_PAL; i++) begin
            rng = xorshift32(rng);
            b_model[i] = rng[3:0];  // upper data nibble is dropped
            cpu_write(TGT_B, pal_addr_t'(i), rng[7:0], (i < 8) ? HOLD_CLK : 0);
        end
        for (i = 0; i < N_PROM; i++) begin
            rng = xorshift32(rng);
            prom_model[i] = rng[3:0];
            cpu_write(TGT_PRIO, {rng[9:8], prom_addr_t'(i)}, rng[7:0], (i < 8) ? HOLD_CLK : 0);
        end

        // new pixel on each enable edge with its result PIPE_DLY + 1 edges later
        next_pixel_edge();
        for (p = 0; p < N_PIX + PIPE_DLY + 2; p++) begin
            rng = xorshift32(rng);
            cv  = rng[6:0];
            sv  = rng[14:7];
            ov  = rng[21:15];
            ons = (p < N_PIX / 2) ? 3'b111 : rng[24:22];  // layers off in the second half
            hb  = (rng[27:25] != 3'd0);
            vb  = (rng[30:28] != 3'd0);
            char_pxl <= cv;
            scr_pxl  <= sv;
            obj_pxl  <= ov;
            char_on  <= ons[2];
            scr_on   <= ons[1];
            obj_on   <= ons[0];
            lhbl     <= hb;
            lvbl     <= vb;
            exp_q.push_back({hb, vb, expected_rgb(cv, sv, ov, ons)});
            @(negedge clk);
            if (exp_q.size() > PIPE_DLY + 1) check_pixel(exp_q.pop_front());
            next_pixel_edge();
        end

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLK) @(posedge clk);
        $display("watchdog expired after %0d clk, the run did not complete", WATCHDOG_CLK);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/video_mixer_top.sv
// video_mixer_top: enable generator, cpu write port, colour mixer and blanking delay
`timescale 1ns/100ps
`default_nettype none

module video_mixer_top import video_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // pixel side
    input  char_code_t  char_pxl,
    input  scr_code_t   scr_pxl,
    input  obj_code_t   obj_pxl,
    input  logic        char_on,
    input  logic        scr_on,
    input  logic        obj_on,
    input  logic        lhbl,       // high in active video
    input  logic        lvbl,
    output rgb4_t       red,
    output rgb4_t       green,
    output rgb4_t       blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly,
    // cpu side
    input  logic        cpu_req,
    input  cpu_target_e cpu_sel,
    input  pal_addr_t   cpu_addr,
    input  cpu_data_t   cpu_data,
    output logic        cpu_ack
);

    logic      cen_pxl;
    logic      cen_prom;
    logic      we_rg;
    logic      we_b;
    logic      we_prio;
    pal_addr_t wr_addr;
    cpu_data_t wr_data;
    rgb4_t     pal_red;
    rgb4_t     pal_green;
    rgb4_t     pal_blue;

    pxl_cen_gen u_cen (
        .clk      (clk),
        .reset    (reset),
        .cen_pxl  (cen_pxl),
        .cen_prom (cen_prom)
    );

    cpu_port u_cpu (
        .clk      (clk),
        .reset    (reset),
        .cen_pxl  (cen_pxl),
        .cpu_req  (cpu_req),
        .cpu_sel  (cpu_sel),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_ack  (cpu_ack),
        .we_rg    (we_rg),
        .we_b     (we_b),
        .we_prio  (we_prio),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    colmix u_mix (
        .clk       (clk),
        .reset     (reset),
        .cen_pxl   (cen_pxl),
        .cen_prom  (cen_prom),
        .char_pxl  (char_pxl),
        .scr_pxl   (scr_pxl),
        .obj_pxl   (obj_pxl),
        .char_on   (char_on),
        .scr_on    (scr_on),
        .obj_on    (obj_on),
        .we_rg     (we_rg),
        .we_b      (we_b),
        .we_prio   (we_prio),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .pal_red   (pal_red),
        .pal_green (pal_green),
        .pal_blue  (pal_blue)
    );

    // flags go straight in, they meet the colour at the last stage
    blank_delay u_blank (
        .clk       (clk),
        .reset     (reset),
        .cen_pxl   (cen_pxl),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .rgb_red   (pal_red),
        .rgb_green (pal_green),
        .rgb_blue  (pal_blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// File: src/colmix.sv
// colmix: layer transparency, priority lookup, palette address mux and palette read
`timescale 1ns/100ps
`default_nettype none

module colmix import video_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cen_pxl,
    input  logic       cen_prom,
    input  char_code_t char_pxl,
    input  scr_code_t  scr_pxl,
    input  obj_code_t  obj_pxl,
    input  logic       char_on,
    input  logic       scr_on,
    input  logic       obj_on,
    input  logic       we_rg,
    input  logic       we_b,
    input  logic       we_prio,
    input  pal_addr_t  wr_addr,
    input  cpu_data_t  wr_data,
    output rgb4_t      pal_red,
    output rgb4_t      pal_green,
    output rgb4_t      pal_blue
);

    logic       char_opaque;
    logic       obj_opaque;
    logic [1:0] scr_grp;              // 0 means behind everything
    prom_addr_t prom_addr;            // registered at pixel n
    char_code_t char0;                // codes held for the mux at n+1
    scr_code_t  scr0;
    obj_code_t  obj0;
    sel_code_t  sel;                  // prom word, ready by n+1
    logic [PAL_AW-3:0] code_mux;      // code inside the bank
    pal_addr_t  pal_addr;             // registered at n+1

    // code 3 in the low bits is the transparent char colour
    assign char_opaque = char_on && !(&char_pxl[1:0]);
    assign obj_opaque  = obj_on  && !(&obj_pxl[3:0]);   // code 15 is see-through
    assign scr_grp     = (scr_pxl[7] || !scr_on) ? 2'b00 : scr_pxl[6:5] + 2'b01;

    // pixel sampling stage
    always_ff @(posedge clk) begin
        if (reset) begin
            prom_addr <= '0;
        end else if (cen_pxl) begin
            prom_addr <= {char_opaque, obj_opaque, scr_grp, scr_pxl[3:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (cen_pxl) begin
            char0 <= char_pxl;
            scr0  <= scr_pxl;
            obj0  <= obj_pxl;
        end
    end

    // source select from the prom word
    always_comb begin
        case (sel[1:0])
            2'b11:   code_mux = {1'b0, char0};
            2'b10:   code_mux = scr0;
            2'b01:   code_mux = {1'b0, obj0};
            default: code_mux = '0;  // nothing shows, bank colour 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr <= '0;
        end else if (cen_pxl) begin
            pal_addr <= {sel[3:2], code_mux};
        end
    end

    prio_prom u_prio (
        .clk      (clk),
        .cen_prom (cen_prom),
        .rd_addr  (prom_addr),
        .we       (we_prio),
        .wr_addr  (wr_addr[PROM_AW-1:0]),  // prom only sees the low byte
        .wr_data  (wr_data[3:0]),
        .q        (sel)
    );

    palette_ram u_pal (
        .clk     (clk),
        .cen_pxl (cen_pxl),
        .rd_addr (pal_addr),
        .we_rg   (we_rg),
        .we_b    (we_b),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .red     (pal_red),
        .green   (pal_green),
        .blue    (pal_blue)
    );

endmodule

`default_nettype wire

// File: src/blank_delay.sv
// blank_delay: blanking flag delay line and blanked colour output register
`timescale 1ns/100ps
`default_nettype none

module blank_delay import video_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cen_pxl,
    input  logic  lhbl,
    input  logic  lvbl,
    input  rgb4_t rgb_red,
    input  rgb4_t rgb_green,
    input  rgb4_t rgb_blue,
    output logic  lhbl_dly,
    output logic  lvbl_dly,
    output rgb4_t red,
    output rgb4_t green,
    output rgb4_t blue
);

    logic [PIPE_DLY-1:0] hbl_sr;  // [0] newest
    logic [PIPE_DLY-1:0] vbl_sr;
    logic                active;  // flags of the pixel now at the colour input

    assign active = hbl_sr[PIPE_DLY-1] && vbl_sr[PIPE_DLY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            hbl_sr   <= '0;
            vbl_sr   <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (cen_pxl) begin
            hbl_sr   <= {hbl_sr[PIPE_DLY-2:0], lhbl};
            vbl_sr   <= {vbl_sr[PIPE_DLY-2:0], lvbl};
            lhbl_dly <= hbl_sr[PIPE_DLY-1];  // same stage as colour
            lvbl_dly <= vbl_sr[PIPE_DLY-1];
            red      <= active ? rgb_red   : '0;  // black outside active video
            green    <= active ? rgb_green : '0;
            blue     <= active ? rgb_blue  : '0;
        end
    end

endmodule

`default_nettype wire

// File: src/palette_ram.sv
// palette_ram: 1024-entry palette, red/green byte bank and blue nibble bank
`timescale 1ns/100ps
`default_nettype none

module palette_ram import video_pkg::*; (
    input  logic      clk,
    input  logic      cen_pxl,
    input  pal_addr_t rd_addr,
    input  logic      we_rg,
    input  logic      we_b,
    input  pal_addr_t wr_addr,
    input  cpu_data_t wr_data,
    output rgb4_t     red,
    output rgb4_t     green,
    output rgb4_t     blue
);

    cpu_data_t rg_mem [0:(1 << PAL_AW) - 1];  // red high nibble, green low nibble
    rgb4_t     b_mem  [0:(1 << PAL_AW) - 1];

    cpu_data_t rg_q;
    rgb4_t     b_q;

    // cpu writes
    always_ff @(posedge clk) begin
        if (we_rg) begin
            rg_mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (we_b) begin
            b_mem[wr_addr] <= wr_data[3:0];  // only the low nibble is stored
        end
    end

    // both banks read on the same index, once per pixel
    always_ff @(posedge clk) begin
        if (cen_pxl) begin
            rg_q <= rg_mem[rd_addr];
            b_q  <= b_mem[rd_addr];
        end
    end

    assign red   = rg_q[7:4];
    assign green = rg_q[3:0];
    assign blue  = b_q;

endmodule

`default_nettype wire

// File: src/prio_prom.sv
// prio_prom: 256x4 writable priority table with registered read
`timescale 1ns/100ps
`default_nettype none

module prio_prom import video_pkg::*; (
    input  logic       clk,
    input  logic       cen_prom,
    input  prom_addr_t rd_addr,
    input  logic       we,
    input  prom_addr_t wr_addr,
    input  sel_code_t  wr_data,
    output sel_code_t  q
);

    sel_code_t mem [0:(1 << PROM_AW) - 1];

    // write port, any clk
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port runs at the prom rate so the word
    // is settled before the next pixel enable
    always_ff @(posedge clk) begin
        if (cen_prom) begin
            q <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: src/cpu_port.sv
// cpu_port: four-phase req/ack write slave issuing pixel-aligned write strobes
`timescale 1ns/100ps
`default_nettype none

module cpu_port import video_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cen_pxl,
    input  logic        cpu_req,
    input  cpu_target_e cpu_sel,
    input  pal_addr_t   cpu_addr,
    input  cpu_data_t   cpu_data,
    output logic        cpu_ack,
    output logic        we_rg,
    output logic        we_b,
    output logic        we_prio,
    output pal_addr_t   wr_addr,
    output cpu_data_t   wr_data
);

    port_state_e state;
    cpu_target_e sel_q;   // latched target
    pal_addr_t   addr_q;
    cpu_data_t   data_q;
    cpu_target_e tgt;
    logic        pending; // a write is waiting for the enable
    logic        fire;

    // a request that meets the enable straight away is written from the bus itself
    assign pending = (state == PORT_IDLE && cpu_req) || state == PORT_WAIT;
    assign fire    = pending && cen_pxl;
    assign tgt     = (state == PORT_IDLE) ? cpu_sel  : sel_q;
    assign wr_addr = (state == PORT_IDLE) ? cpu_addr : addr_q;
    assign wr_data = (state == PORT_IDLE) ? cpu_data : data_q;

    assign we_rg   = fire && tgt == TGT_RG;
    assign we_b    = fire && tgt == TGT_B;
    assign we_prio = fire && tgt == TGT_PRIO;
    assign cpu_ack = (state == PORT_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE: if (cpu_req) state <= cen_pxl ? PORT_ACK : PORT_WAIT;
                PORT_WAIT: if (cen_pxl) state <= PORT_ACK;  // strobe fires this cycle
                PORT_ACK:  if (!cpu_req) state <= PORT_IDLE; // master let go
                default:   state <= PORT_IDLE;
            endcase
        end
    end

    // payload capture, no reset needed
    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && cpu_req) begin
            sel_q  <= cpu_sel;
            addr_q <= cpu_addr;
            data_q <= cpu_data;
        end
    end

endmodule

`default_nettype wire

// File: src/pxl_cen_gen.sv
// pxl_cen_gen: pixel enable and double-rate prom enable from a free-running counter
`timescale 1ns/100ps
`default_nettype none

module pxl_cen_gen import video_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic cen_pxl,   // one clk in CEN_DIV
    output logic cen_prom   // twice the pixel rate
);

    logic [CEN_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;  // wraps on its own
        end
    end

    // pixel enable on the last count, so the first one lands on the 4th cycle
    assign cen_pxl  = (cnt == CEN_W'(CEN_DIV - 1));
    assign cen_prom = cnt[0];  // odd counts, the mid-period pulse lands half a pixel early

endmodule

`default_nettype wire

// File: src/video_pkg.sv
// video mixer package: widths, pipeline depth, enable ratio, code typedefs and state enums
`default_nettype none

package video_pkg;

    localparam int PAL_AW   = 10;               // palette index width
    localparam int PROM_AW  = 8;                // priority prom index width
    localparam int PIPE_DLY = 3;                // pixel periods from sampling to colour register
    localparam int CEN_DIV  = 4;                // clk cycles per pixel enable
    localparam int CEN_W    = $clog2(CEN_DIV);  // enable counter width

    // raw layer codes
    typedef logic [6:0] char_code_t;
    typedef logic [6:0] obj_code_t;
    typedef logic [7:0] scr_code_t;  // [7] behind all, [6:5] group, [3:0] colour

    typedef logic [PAL_AW-1:0]  pal_addr_t;
    typedef logic [PROM_AW-1:0] prom_addr_t;
    typedef logic [3:0]         sel_code_t;  // [3:2] bank, [1:0] source
    typedef logic [3:0]         rgb4_t;
    typedef logic [7:0]         cpu_data_t;

    // cpu write target
    typedef enum logic [1:0] {
        TGT_RG   = 2'd0,  // red/green palette byte
        TGT_B    = 2'd1,  // blue palette nibble
        TGT_PRIO = 2'd2   // priority prom word
    } cpu_target_e;

    // cpu port handshake states
    typedef enum logic [1:0] {
        PORT_IDLE = 2'd0,
        PORT_WAIT = 2'd1,  // write latched, waiting for pixel enable
        PORT_ACK  = 2'd2   // write done, ack held until req drops
    } port_state_e;

endpackage

`default_nettype wire
